/* source/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath
`define CPU_XLEN 32

// register file
`define CPU_REG_ADDR_W 5
`define CPU_REG_COUNT 32

// instruction memory, in words
`define CPU_IMEM_DEPTH 64
`define CPU_IMEM_ADDR_W 6

// program count
`define CPU_PC_STEP 4
`define CPU_RESET_PC 0

`endif

/* source/cpu_isa_pkg.sv */
`include "cpu_defines.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CPU_XLEN-1:0] pc_t; // byte address
    typedef logic [`CPU_IMEM_ADDR_W-1:0] imem_addr_t; // word index

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of the arithmetic groups
    typedef enum logic [2:0] {
        F3_ADD = 3'b000, // add, sub, addi
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

endpackage

/* source/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

    typedef struct packed {
        cpu_isa_pkg::pc_t   pc;
        cpu_isa_pkg::word_t instr;
    } fetch_out_t;

    typedef struct packed {
        cpu_isa_pkg::pc_t       pc;
        cpu_isa_pkg::alu_op_e   alu_op;
        cpu_isa_pkg::word_t     op_a;
        cpu_isa_pkg::word_t     op_b; // immediate for branch and jal
        cpu_isa_pkg::reg_addr_t rd;
        logic                   we;
        logic                   branch;
        logic                   beq; // branch on equal, else on not equal
        logic                   jump;
        logic                   halt;
        cpu_isa_pkg::word_t     rs2_data; // compare operand
    } decode_out_t;

    typedef struct packed {
        cpu_isa_pkg::pc_t       pc;
        cpu_isa_pkg::pc_t       next_pc;
        cpu_isa_pkg::reg_addr_t rd;
        logic                   we;
        cpu_isa_pkg::word_t     result;
        logic                   halt;
    } exec_out_t;

    // one record per finished instruction
    typedef struct packed {
        cpu_isa_pkg::pc_t       pc;
        cpu_isa_pkg::reg_addr_t rd;
        logic                   we;
        cpu_isa_pkg::word_t     data;
    } retire_t;

endpackage

/* source/register_file.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_isa_pkg::reg_addr_t rs1_addr,
    input  cpu_isa_pkg::reg_addr_t rs2_addr,
    output cpu_isa_pkg::word_t     rs1_data,
    output cpu_isa_pkg::word_t     rs2_data,
    input  logic                   wr_en,
    input  cpu_isa_pkg::reg_addr_t wr_addr,
    input  cpu_isa_pkg::word_t     wr_data
);

    cpu_isa_pkg::word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            regs <= '{default: '0};
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 reads zero on both ports
    a_x0_zero : assert property (
        @(posedge clk) disable iff (!rst)
        (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0)
    );

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pc_valid,
    input  cpu_isa_pkg::pc_t         pc,
    output logic                     stall,
    input  logic                     load_en,
    input  cpu_isa_pkg::imem_addr_t  load_addr,
    input  cpu_isa_pkg::word_t       load_data,
    output logic                     done_next,
    output cpu_pipe_pkg::fetch_out_t fetch_out,
    input  logic                     stall_next
);

    cpu_isa_pkg::word_t imem [`CPU_IMEM_DEPTH];
    cpu_isa_pkg::imem_addr_t rd_index;
    logic imem_we;
    logic take;

    assign imem_we = load_en && !rst; // program load only while held in reset
    assign rd_index = pc[`CPU_IMEM_ADDR_W+1:2];
    assign stall = done_next && stall_next;
    assign take = pc_valid && !stall;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_next <= 1'b0;
        end else if (take) begin
            done_next <= 1'b1;
        end else if (!stall_next) begin
            done_next <= 1'b0;
        end
    end

    // registered read of the addressed word
    always_ff @(posedge clk) begin
        if (take) begin
            fetch_out.pc <= pc;
            fetch_out.instr <= imem[rd_index];
        end
    end

    // the memory keeps its contents while the core runs
    a_load_in_reset : assert property (
        @(posedge clk)
        rst && load_en |=> imem[$past(load_addr)] === $past(imem[load_addr])
    );

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      done_prev,
    input  cpu_pipe_pkg::fetch_out_t  fetch_in,
    output logic                      stall,
    output cpu_isa_pkg::reg_addr_t    rs1_addr,
    output cpu_isa_pkg::reg_addr_t    rs2_addr,
    input  cpu_isa_pkg::word_t        rs1_data,
    input  cpu_isa_pkg::word_t        rs2_data,
    output logic                      done_next,
    output cpu_pipe_pkg::decode_out_t decode_out,
    input  logic                      stall_next
);

    cpu_isa_pkg::word_t instr;
    cpu_isa_pkg::opcode_e opcode;
    cpu_isa_pkg::funct3_e funct3;
    cpu_isa_pkg::word_t imm_i;
    cpu_isa_pkg::word_t imm_b;
    cpu_isa_pkg::word_t imm_j;
    cpu_isa_pkg::word_t imm_u;
    cpu_pipe_pkg::decode_out_t dec;
    logic take;

    assign instr = fetch_in.instr;
    assign opcode = cpu_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = cpu_isa_pkg::funct3_e'(instr[14:12]);
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec = '0;
        dec.pc = fetch_in.pc;
        dec.rd = instr[11:7];
        dec.rs2_data = rs2_data;
        dec.op_a = rs1_data;
        dec.alu_op = cpu_isa_pkg::ALU_ADD;
        case (opcode)
            cpu_isa_pkg::OPC_OP, cpu_isa_pkg::OPC_OP_IMM: begin
                dec.we = 1'b1;
                dec.op_b = (opcode == cpu_isa_pkg::OPC_OP) ? rs2_data : imm_i;
                case (funct3)
                    cpu_isa_pkg::F3_ADD: dec.alu_op = (opcode == cpu_isa_pkg::OPC_OP && instr[30])
                                                      ? cpu_isa_pkg::ALU_SUB : cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::F3_SLT: dec.alu_op = cpu_isa_pkg::ALU_SLT;
                    cpu_isa_pkg::F3_XOR: dec.alu_op = cpu_isa_pkg::ALU_XOR;
                    cpu_isa_pkg::F3_OR:  dec.alu_op = cpu_isa_pkg::ALU_OR;
                    cpu_isa_pkg::F3_AND: dec.alu_op = cpu_isa_pkg::ALU_AND;
                    default:             dec.we = 1'b0; // unsupported funct3
                endcase
            end
            cpu_isa_pkg::OPC_LUI: begin
                dec.we = 1'b1;
                dec.op_a = '0;
                dec.op_b = imm_u;
            end
            cpu_isa_pkg::OPC_JAL: begin
                dec.we = 1'b1;
                dec.jump = 1'b1;
                dec.op_a = fetch_in.pc;
                dec.op_b = imm_j;
                dec.alu_op = cpu_isa_pkg::ALU_PASS_B; // link replaces the alu result
            end
            cpu_isa_pkg::OPC_BRANCH: begin
                dec.branch = 1'b1;
                dec.beq = !instr[12];
                dec.op_b = imm_b;
            end
            cpu_isa_pkg::OPC_SYSTEM: dec.halt = 1'b1; // ecall
            default: dec.we = 1'b0; // unknown opcode retires as a no-op
        endcase
    end

    assign stall = done_next && stall_next;
    assign take = done_prev && !stall;

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_next <= 1'b0;
        end else if (take) begin
            done_next <= 1'b1;
        end else if (!stall_next) begin
            done_next <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            decode_out <= dec;
        end
    end

    a_idle_after_reset : assert property (
        @(posedge clk)
        !rst |=> !done_next
    );

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      done_prev,
    input  cpu_pipe_pkg::decode_out_t decode_in,
    output logic                      stall,
    output logic                      done_next,
    output cpu_pipe_pkg::exec_out_t   exec_out,
    input  logic                      stall_next
);

    cpu_isa_pkg::word_t alu_y;
    cpu_isa_pkg::pc_t link_pc;
    cpu_isa_pkg::pc_t target_pc;
    logic taken;
    logic take;

    always_comb begin
        case (decode_in.alu_op)
            cpu_isa_pkg::ALU_ADD:    alu_y = decode_in.op_a + decode_in.op_b;
            cpu_isa_pkg::ALU_SUB:    alu_y = decode_in.op_a - decode_in.op_b;
            cpu_isa_pkg::ALU_AND:    alu_y = decode_in.op_a & decode_in.op_b;
            cpu_isa_pkg::ALU_OR:     alu_y = decode_in.op_a | decode_in.op_b;
            cpu_isa_pkg::ALU_XOR:    alu_y = decode_in.op_a ^ decode_in.op_b;
            cpu_isa_pkg::ALU_SLT:    alu_y = {31'b0, $signed(decode_in.op_a) < $signed(decode_in.op_b)};
            cpu_isa_pkg::ALU_PASS_B: alu_y = decode_in.op_b;
            default:                 alu_y = '0;
        endcase
    end

    assign link_pc = decode_in.pc + `CPU_PC_STEP;
    assign target_pc = decode_in.pc + decode_in.op_b; // op_b holds the b or j immediate
    assign taken = decode_in.branch
                   && ((decode_in.op_a == decode_in.rs2_data) == decode_in.beq);

    assign stall = done_next && stall_next;
    assign take = done_prev && !stall;

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_next <= 1'b0;
        end else if (take) begin
            done_next <= 1'b1;
        end else if (!stall_next) begin
            done_next <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            exec_out.pc <= decode_in.pc;
            exec_out.next_pc <= (decode_in.jump || taken) ? target_pc : link_pc;
            exec_out.rd <= decode_in.rd;
            exec_out.we <= decode_in.we;
            exec_out.result <= decode_in.jump ? link_pc : alu_y;
            exec_out.halt <= decode_in.halt;
        end
    end

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    done_prev,
    input  cpu_pipe_pkg::exec_out_t exec_in,
    output logic                    stall,
    output logic                    wr_en,
    output cpu_isa_pkg::reg_addr_t  wr_addr,
    output cpu_isa_pkg::word_t      wr_data,
    output logic                    retire_valid,
    output cpu_pipe_pkg::retire_t   retire,
    output logic                    done_next,
    output cpu_isa_pkg::pc_t        next_pc,
    output logic                    halt,
    input  logic                    stall_next
);

    cpu_pipe_pkg::exec_out_t held;
    logic take;

    assign stall = done_next && stall_next;
    assign take = done_prev && !stall;

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_next <= 1'b0;
        end else if (take) begin
            done_next <= 1'b1;
        end else if (!stall_next) begin
            done_next <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= exec_in;
        end
    end

    // register write and retire land on the edge the token goes back to the core
    assign retire_valid = done_next && !stall_next;
    assign wr_en = retire_valid && held.we && held.rd != '0;
    assign wr_addr = held.rd;
    assign wr_data = held.result;

    assign retire.pc = held.pc;
    assign retire.rd = held.rd;
    assign retire.we = held.we; // x0 writes are still reported
    assign retire.data = held.result;

    assign next_pc = held.next_pc;
    assign halt = held.halt;

    a_single_retire : assert property (
        @(posedge clk) disable iff (!rst)
        retire_valid |=> !retire_valid && !done_next
    );

endmodule

/* source/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_en,
    input  cpu_isa_pkg::imem_addr_t load_addr,
    input  cpu_isa_pkg::word_t      load_data,
    output logic                    retire_valid,
    output cpu_pipe_pkg::retire_t   retire,
    output logic                    halted
);

    cpu_isa_pkg::pc_t pc_q;
    logic pc_queued;
    logic pc_valid;
    logic token_stall;

    logic fetch_stall;
    logic fetch_done;
    cpu_pipe_pkg::fetch_out_t fetch_out;
    logic decode_stall;
    logic decode_done;
    cpu_pipe_pkg::decode_out_t decode_out;
    logic exec_stall;
    logic exec_done;
    cpu_pipe_pkg::exec_out_t exec_out;
    logic wb_stall;
    logic wb_done;
    cpu_isa_pkg::pc_t wb_next_pc;
    logic wb_halt;

    cpu_isa_pkg::reg_addr_t rs1_addr;
    cpu_isa_pkg::reg_addr_t rs2_addr;
    cpu_isa_pkg::word_t rs1_data;
    cpu_isa_pkg::word_t rs2_data;
    logic wr_en;
    cpu_isa_pkg::reg_addr_t wr_addr;
    cpu_isa_pkg::word_t wr_data;

    assign pc_valid = rst && pc_queued;
    assign token_stall = pc_queued; // token slot still occupied

    // single program-count token recycled from writeback
    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_q <= `CPU_RESET_PC;
            pc_queued <= 1'b1;
            halted <= 1'b0;
        end else if (wb_done && !token_stall) begin
            pc_q <= wb_next_pc;
            pc_queued <= !wb_halt;
            halted <= wb_halt;
        end else if (pc_valid && !fetch_stall) begin
            pc_queued <= 1'b0;
        end
    end

    fetch_stage i_fetch (
        .clk(clk), .rst(rst), .pc_valid(pc_valid), .pc(pc_q), .stall(fetch_stall),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .done_next(fetch_done), .fetch_out(fetch_out), .stall_next(decode_stall)
    );

    decode_stage i_decode (
        .clk(clk), .rst(rst), .done_prev(fetch_done), .fetch_in(fetch_out),
        .stall(decode_stall), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .done_next(decode_done),
        .decode_out(decode_out), .stall_next(exec_stall)
    );

    execute_stage i_execute (
        .clk(clk), .rst(rst), .done_prev(decode_done), .decode_in(decode_out),
        .stall(exec_stall), .done_next(exec_done), .exec_out(exec_out),
        .stall_next(wb_stall)
    );

    writeback_stage i_writeback (
        .clk(clk), .rst(rst), .done_prev(exec_done), .exec_in(exec_out),
        .stall(wb_stall), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .retire_valid(retire_valid), .retire(retire), .done_next(wb_done),
        .next_pc(wb_next_pc), .halt(wb_halt), .stall_next(token_stall)
    );

    register_file i_regs (
        .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
    end

    always #2 clk = ~clk; // 4 ns period

endmodule

/* dv/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker #(
    parameter int max_retires = 128
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retire_valid,
    input  cpu_pipe_pkg::retire_t retire,
    input  logic                  halted,
    input  cpu_pipe_pkg::retire_t expected [max_retires],
    input  int                    expected_len,
    input  logic [8*12-1:0]       test_name,
    output logic                  test_done,
    output int                    tests_passed,
    output int                    tests_failed
);

    int seen;
    int gap;
    int errors;
    int quiet;
    logic halt_due;
    logic halt_seen;

    initial begin
        test_done = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic compare_retire();
        cpu_pipe_pkg::retire_t exp;
        exp = expected[seen];
        if (retire.pc !== exp.pc || retire.rd !== exp.rd || retire.we !== exp.we
            || (exp.we && retire.data !== exp.data)) begin
            $display("** Error at %0t: retire %0d pc %h/%h rd %0d/%0d we %b/%b data %h/%h",
                     $time, seen, retire.pc, exp.pc, retire.rd, exp.rd,
                     retire.we, exp.we, retire.data, exp.data); // got/expected
            errors = errors + 1;
        end
        if (seen > 0 && gap != 5) begin
            $display("** Error at %0t: retire %0d came %0d cycles after the previous one",
                     $time, seen, gap);
            errors = errors + 1;
        end
    endtask

    // sampled mid-cycle, away from the edges that move the core
    always @(negedge clk) begin
        if (!rst) begin
            seen = 0;
            gap = 0;
            errors = 0;
            quiet = 0;
            halt_due = 1'b0;
            halt_seen = 1'b0;
            test_done = 1'b0;
        end else if (!test_done) begin
            gap = gap + 1;
            if (halt_due) begin
                if (!halted) begin
                    $display("halted did not rise after ECALL retired, at %0t", $time);
                    errors = errors + 1;
                end
                halt_due = 1'b0;
                halt_seen = 1'b1;
            end else if (halted && !halt_seen) begin
                $display("halted rose before the halting instruction retired, at %0t", $time);
                errors = errors + 1;
                halt_seen = 1'b1;
            end
            if (retire_valid) begin
                if (halt_seen) begin
                    $display("an instruction retired after the core halted, at %0t", $time);
                    errors = errors + 1;
                end else if (seen >= expected_len) begin
                    $display("more instructions retired than the model expects, at %0t", $time);
                    errors = errors + 1;
                end else begin
                    compare_retire();
                    if (seen == expected_len - 1) halt_due = 1'b1; // last one is the ecall
                end
                seen = seen + 1;
                gap = 0;
            end
            if (halt_seen) begin
                quiet = quiet + 1; // watch a few idle cycles for stray retires
                if (quiet == 10) begin
                    if (errors == 0 && seen == expected_len) begin
                        tests_passed = tests_passed + 1;
                        $display("test %0s: pass, %0d retires", test_name, seen);
                    end else begin
                        tests_failed = tests_failed + 1;
                        $display("test %0s: FAIL, %0d of %0d retires, %0d errors",
                                 test_name, seen, expected_len, errors);
                    end
                    test_done = 1'b1;
                end
            end
        end
    end

endmodule

/* dv/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int max_retires = 128;
    localparam cpu_isa_pkg::word_t ecall_word = 32'h0000_0073;

    logic clk;
    logic por_rst;
    logic run;
    logic rst;
    logic load_en;
    cpu_isa_pkg::imem_addr_t load_addr;
    cpu_isa_pkg::word_t load_data;
    logic retire_valid;
    cpu_pipe_pkg::retire_t retire;
    logic halted;

    cpu_isa_pkg::word_t prog [64];
    int plen;
    cpu_isa_pkg::word_t model_regs [32];
    cpu_isa_pkg::pc_t model_pc;
    cpu_pipe_pkg::retire_t expected [max_retires];
    int expected_len;
    logic [8*12-1:0] test_name;
    logic test_done;
    int tests_passed;
    int tests_failed;
    int cycles = 0;
    int cycle_limit = 100; // margin, grows with every test
    integer seed;

    assign rst = por_rst && run;

    clock_gen i_clock_gen (.clk(clk), .rst(por_rst));

    cpu_core i_cpu_core (
        .clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .retire_valid(retire_valid), .retire(retire), .halted(halted)
    );

    cpu_checker #(.max_retires(max_retires)) i_checker (
        .clk(clk), .rst(rst), .retire_valid(retire_valid), .retire(retire), .halted(halted),
        .expected(expected), .expected_len(expected_len), .test_name(test_name),
        .test_done(test_done), .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    task automatic emit(input cpu_isa_pkg::word_t w);
        prog[plen] = w;
        plen = plen + 1;
    endtask

    task automatic emit_r(input int sub, input int f3, input int rd, input int rs1, input int rs2);
        emit({(sub != 0) ? 7'h20 : 7'h00, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33});
    endtask

    task automatic emit_i(input int f3, input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13});
    endtask

    task automatic emit_u(input int rd, input int imm);
        emit({imm[19:0], rd[4:0], 7'h37});
    endtask

    task automatic emit_b(input int f3, input int rs1, input int rs2, input int off);
        emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63});
    endtask

    task automatic emit_j(input int rd, input int off);
        emit({off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f});
    endtask

    // architectural model, one instruction per call
    function automatic void model_step(output cpu_pipe_pkg::retire_t rec, output logic halt);
        cpu_isa_pkg::word_t ins;
        cpu_isa_pkg::word_t a;
        cpu_isa_pkg::word_t b;
        cpu_isa_pkg::word_t res;
        cpu_isa_pkg::pc_t npc;
        logic we;
        ins = prog[model_pc[7:2]];
        a = model_regs[ins[19:15]];
        b = (ins[6:0] == 7'h33) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        npc = model_pc + 32'd4;
        res = '0;
        we = 1'b0;
        halt = 1'b0;
        case (ins[6:0])
            7'h33, 7'h13: begin
                we = 1'b1;
                case (ins[14:12])
                    3'b000: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100: res = a ^ b;
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: we = 1'b0;
                endcase
            end
            7'h37: begin
                we = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            7'h6f: begin
                we = 1'b1;
                res = model_pc + 32'd4;
                npc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h63: begin
                if ((a == model_regs[ins[24:20]]) != ins[12]) begin // funct3 bit 0 picks bne
                    npc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'h73: halt = 1'b1;
            default: we = 1'b0;
        endcase
        if (we && ins[11:7] != 5'd0) model_regs[ins[11:7]] = res;
        rec.pc = model_pc;
        rec.rd = ins[11:7];
        rec.we = we;
        rec.data = res;
        model_pc = npc;
    endfunction

    task automatic build_expected();
        cpu_pipe_pkg::retire_t rec;
        logic halt;
        model_pc = '0;
        model_regs = '{default: '0};
        expected_len = 0;
        halt = 1'b0;
        while (!halt && expected_len < max_retires) begin
            model_step(rec, halt);
            expected[expected_len] = rec;
            expected_len = expected_len + 1;
        end
    endtask

    task automatic new_program();
        prog = '{default: '0};
        plen = 0;
    endtask

    // load while held in reset, then release and wait for the checker
    task automatic run_test(input logic [8*12-1:0] name);
        test_name = name;
        build_expected();
        cycle_limit = cycle_limit + expected_len * 5 + plen + 30;
        @(posedge clk);
        run <= 1'b0;
        for (int i = 0; i < plen; i++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= cpu_isa_pkg::imem_addr_t'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (5) @(posedge clk);
        run <= 1'b1;
        while (!test_done) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int kind;
        seed = 73207;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;

        new_program();
        emit_i(0, 1, 0, 5);
        emit_i(0, 2, 0, 7);
        emit_u(3, 'h80000); // most negative value
        emit_r(0, 0, 4, 1, 2);
        emit_r(1, 0, 5, 1, 2); // 5 - 7 wraps
        emit_r(0, 7, 6, 1, 2);
        emit_r(0, 6, 7, 1, 2);
        emit_r(0, 4, 8, 1, 2);
        emit_r(0, 2, 9, 1, 2);
        emit_r(0, 2, 10, 3, 1);
        emit_r(0, 2, 11, 1, 3);
        emit(ecall_word);
        run_test("alu_rr");

        new_program();
        emit_i(0, 1, 0, -1);
        emit_i(7, 2, 1, -16);
        emit_i(6, 3, 0, -2048);
        emit_i(4, 4, 1, -1);
        emit_i(0, 5, 1, -2048);
        emit_u(6, 'hABCDE);
        emit_i(0, 7, 6, -1);
        emit(ecall_word);
        run_test("imm_lui");

        new_program();
        emit_i(0, 0, 0, 9);
        emit_i(0, 1, 0, 3);
        emit_r(0, 0, 0, 1, 1);
        emit_r(0, 0, 2, 0, 1);
        emit_u(0, 'h12345);
        emit(32'h0000_00ff); // unknown opcode aimed at x1
        emit_r(0, 6, 3, 0, 1);
        emit(ecall_word);
        run_test("x0_write");

        new_program();
        emit_i(0, 1, 0, 1);
        emit_i(0, 2, 0, 1);
        emit_b(0, 1, 2, 8); // taken
        emit_i(0, 3, 0, 99);
        emit_b(1, 1, 2, 8); // not taken
        emit_i(0, 3, 0, 2);
        emit_b(1, 1, 3, 12); // taken
        emit_i(0, 4, 0, 77);
        emit(ecall_word);
        emit_b(0, 1, 3, 8); // not taken
        emit_j(5, 12);
        emit_i(0, 6, 0, 55);
        emit(ecall_word);
        emit_j(0, -4); // back to the ecall
        run_test("branch_jal");

        new_program();
        for (int k = 0; k < 40; k++) begin
            kind = {$random(seed)} % 11;
            case (kind)
                0, 1: emit_r(kind, 0, $random(seed), $random(seed), $random(seed));
                2: emit_r(0, 7, $random(seed), $random(seed), $random(seed));
                3: emit_r(0, 6, $random(seed), $random(seed), $random(seed));
                4: emit_r(0, 4, $random(seed), $random(seed), $random(seed));
                5: emit_r(0, 2, $random(seed), $random(seed), $random(seed));
                6: emit_i(0, $random(seed), $random(seed), $random(seed));
                7: emit_i(7, $random(seed), $random(seed), $random(seed));
                8: emit_i(6, $random(seed), $random(seed), $random(seed));
                9: emit_i(4, $random(seed), $random(seed), $random(seed));
                default: emit_u($random(seed), $random(seed));
            endcase
        end
        emit(ecall_word);
        run_test("random");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == 5) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+source
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_core.sv
dv/clock_gen.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | tee run.log
	@if grep -q "Errors found" run.log; then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" run.log || (echo "simulation ended without a result"; exit 1)

obj_dir/Vcpu_tb: project.f $(wildcard source/*.sv source/*.svh dv/*.sv)
	verilator --binary --timing -j 0 --top-module cpu_tb -f project.f -o Vcpu_tb

lint:
	verilator --lint-only --timing --top-module cpu_tb -f project.f

clean:
	rm -rf obj_dir run.log
